// ==== hdl/sprite_params.svh ====
`ifndef SPRITE_PARAMS_SVH
`define SPRITE_PARAMS_SVH

// sprite count, the design also works with 8
`define NUM_SPRITES 4

// beam geometry in dots and lines
`define LINE_DOTS 96
`define FRAME_LINES 48
`define X_W 7
`define Y_W 6

// unexpanded sprite height and shifter alignment delay in dots
`define SPRITE_LINES 21
`define PIX_DELAY 3

// apb bus widths
`define APB_AW 8
`define APB_DW 32

// per-sprite banks, one word per sprite at spacing 4
`define A_SPR_X 8'h00
`define A_SPR_Y 8'h20
`define A_SPR_DATA 8'h40

// single-word registers
`define A_EN 8'h60
`define A_XE 8'h64
`define A_YE 8'h68
`define A_MMC 8'h6c
`define A_M2M 8'h70
`define A_M2D 8'h74
`define A_IRQ 8'h78

`endif

// ==== hdl/sprite_pkg.sv ====
package sprite_pkg;

    // one pattern line, bitwise in hi-res and pairwise in multicolor
    typedef union packed {
        logic [23:0] hires;
        logic [11:0][1:0] mc;
    } sprite_data_u;

    // 0 transparent, 1 multicolor 0, 2 sprite color, 3 multicolor 1
    typedef logic [1:0] pix_code_t;

    localparam pix_code_t PIX_TRANSP = 2'd0;
    // a set hi-res bit shows in the sprite color
    localparam pix_code_t PIX_SPR = 2'd2;

endpackage

// ==== hdl/sprite_regs.sv ====
`timescale 1ns/100ps

`include "sprite_params.svh"

module sprite_regs (
    input  logic                                    clk_dot4x,
    input  logic                                    rst,
    input  logic [`APB_AW-1:0]                      paddr,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [`APB_DW-1:0]                      pwdata,
    input  logic [`NUM_SPRITES-1:0]                 m2m_set,
    input  logic [`NUM_SPRITES-1:0]                 m2d_set,
    input  logic                                    immc,
    input  logic                                    imbc,
    output logic [`APB_DW-1:0]                      prdata,
    output logic                                    pready,
    output logic [`NUM_SPRITES-1:0][`X_W-1:0]       spr_x,
    output logic [`NUM_SPRITES-1:0][`Y_W-1:0]       spr_y,
    output logic [`NUM_SPRITES-1:0]                 spr_en,
    output logic [`NUM_SPRITES-1:0]                 spr_xe,
    output logic [`NUM_SPRITES-1:0]                 spr_ye,
    output logic [`NUM_SPRITES-1:0]                 spr_mmc,
    output sprite_pkg::sprite_data_u [`NUM_SPRITES-1:0] spr_data,
    output logic                                    m2m_read,
    output logic                                    m2d_read,
    output logic                                    irq
);

    logic                    wr_acc;
    logic                    rd_acc;
    logic                    irq_wr;
    logic [`NUM_SPRITES-1:0] m2m;
    logic [`NUM_SPRITES-1:0] m2d;
    // bit 0 immc, bit 1 imbc
    logic [1:0]              irq_flags;

    // no wait states, access phase completes at once
    assign pready = 1'b1;
    assign wr_acc = psel & penable & pwrite;
    assign rd_acc = psel & penable & ~pwrite;
    assign irq_wr = wr_acc && paddr == `A_IRQ;

    assign m2m_read = rd_acc && paddr == `A_M2M;
    assign m2d_read = rd_acc && paddr == `A_M2D;
    assign irq = |irq_flags;

    // per-sprite banks
    always_ff @(posedge clk_dot4x) begin
        for (int n = 0; n < `NUM_SPRITES; n++) begin
            if (wr_acc && paddr == `A_SPR_X + `APB_AW'(4 * n))
                spr_x[n] <= pwdata[`X_W-1:0];
            if (wr_acc && paddr == `A_SPR_Y + `APB_AW'(4 * n))
                spr_y[n] <= pwdata[`Y_W-1:0];
            if (wr_acc && paddr == `A_SPR_DATA + `APB_AW'(4 * n))
                spr_data[n].hires <= pwdata[23:0];
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            spr_en <= '0;
            spr_xe <= '0;
            spr_ye <= '0;
            spr_mmc <= '0;
            m2m <= '0;
            m2d <= '0;
            irq_flags <= 2'b00;
        end else begin
            // a read returns the old bits and clears, new hits still land
            m2m <= (m2m_read ? '0 : m2m) | m2m_set;
            m2d <= (m2d_read ? '0 : m2d) | m2d_set;
            irq_flags <= (irq_flags & ~(irq_wr ? pwdata[1:0] : 2'b00)) | {imbc, immc};
            if (wr_acc) begin
                case (paddr)
                    `A_EN:  spr_en <= pwdata[`NUM_SPRITES-1:0];
                    `A_XE:  spr_xe <= pwdata[`NUM_SPRITES-1:0];
                    `A_YE:  spr_ye <= pwdata[`NUM_SPRITES-1:0];
                    `A_MMC: spr_mmc <= pwdata[`NUM_SPRITES-1:0];
                    default: ;
                endcase
            end
        end
    end

    // read data is valid in the access cycle
    always_comb begin
        prdata = '0;
        for (int n = 0; n < `NUM_SPRITES; n++) begin
            if (paddr == `A_SPR_X + `APB_AW'(4 * n))
                prdata[`X_W-1:0] = spr_x[n];
            if (paddr == `A_SPR_Y + `APB_AW'(4 * n))
                prdata[`Y_W-1:0] = spr_y[n];
            if (paddr == `A_SPR_DATA + `APB_AW'(4 * n))
                prdata[23:0] = spr_data[n].hires;
        end
        case (paddr)
            `A_EN:  prdata[`NUM_SPRITES-1:0] = spr_en;
            `A_XE:  prdata[`NUM_SPRITES-1:0] = spr_xe;
            `A_YE:  prdata[`NUM_SPRITES-1:0] = spr_ye;
            `A_MMC: prdata[`NUM_SPRITES-1:0] = spr_mmc;
            `A_M2M: prdata[`NUM_SPRITES-1:0] = m2m;
            `A_M2D: prdata[`NUM_SPRITES-1:0] = m2d;
            `A_IRQ: prdata[1:0] = irq_flags;
            default: ;
        endcase
    end

endmodule

// ==== hdl/beam_timer.sv ====
`timescale 1ns/100ps

`include "sprite_params.svh"

module beam_timer (
    input  logic             clk_dot4x,
    input  logic             rst,
    output logic             dot_tick,
    output logic [`X_W-1:0]  beam_x,
    output logic [`Y_W-1:0]  beam_line
);

    localparam logic [`X_W-1:0] LAST_X = `LINE_DOTS - 1;
    localparam logic [`Y_W-1:0] LAST_LINE = `FRAME_LINES - 1;

    // four clocks per dot
    logic [1:0] phase;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase <= 2'd0;
            dot_tick <= 1'b0;
            beam_x <= '0;
            beam_line <= '0;
        end else begin
            phase <= phase + 2'd1;
            // registered, so the strobe lands on the fourth clock
            dot_tick <= (phase == 2'd2);
            if (dot_tick) begin
                if (beam_x == LAST_X) begin
                    beam_x <= '0;
                    if (beam_line == LAST_LINE)
                        beam_line <= '0;
                    else
                        beam_line <= beam_line + 1'b1;
                end else begin
                    beam_x <= beam_x + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/sprite_shifter.sv ====
`timescale 1ns/100ps

`include "sprite_params.svh"

module sprite_shifter (
    input  logic                                    clk_dot4x,
    input  logic                                    rst,
    input  logic                                    dot_tick,
    input  logic [`X_W-1:0]                         beam_x,
    input  logic [`Y_W-1:0]                         beam_line,
    input  logic [`NUM_SPRITES-1:0][`X_W-1:0]       spr_x,
    input  logic [`NUM_SPRITES-1:0][`Y_W-1:0]       spr_y,
    input  logic [`NUM_SPRITES-1:0]                 spr_en,
    input  logic [`NUM_SPRITES-1:0]                 spr_xe,
    input  logic [`NUM_SPRITES-1:0]                 spr_ye,
    input  logic [`NUM_SPRITES-1:0]                 spr_mmc,
    input  sprite_pkg::sprite_data_u [`NUM_SPRITES-1:0] spr_data,
    output logic                                    dot_tick_d,
    output sprite_pkg::pix_code_t [`NUM_SPRITES-1:0] spr_pix,
    output logic [`X_W-1:0]                         pix_x
);

    import sprite_pkg::*;

    localparam logic [`Y_W:0] WIN_1X = `SPRITE_LINES;
    localparam logic [`Y_W:0] WIN_2X = 2 * `SPRITE_LINES;

    sprite_data_u [`NUM_SPRITES-1:0]    shift_reg;
    sprite_data_u [`NUM_SPRITES-1:0]    src;
    pix_code_t [`NUM_SPRITES-1:0]       cur_pix;
    pix_code_t [`NUM_SPRITES-1:0]       pix_dly [`PIX_DELAY];
    logic [`X_W-1:0]                    x_dly [`PIX_DELAY+1];
    logic [`NUM_SPRITES-1:0][`Y_W:0]    y_end;
    logic [`NUM_SPRITES-1:0]            y_act;
    logic [`NUM_SPRITES-1:0]            x_match;
    logic [`NUM_SPRITES-1:0]            active;
    logic [`NUM_SPRITES-1:0]            xe_ff;
    logic [`NUM_SPRITES-1:0]            mmc_ff;
    logic [`NUM_SPRITES-1:0]            xe_ph;
    logic [`NUM_SPRITES-1:0]            mc_ph;

    always_comb begin
        for (int n = 0; n < `NUM_SPRITES; n++) begin
            y_end[n] = {1'b0, spr_y[n]} + (spr_ye[n] ? WIN_2X : WIN_1X);
            y_act[n] = spr_en[n] && {1'b0, beam_line} >= {1'b0, spr_y[n]}
                       && {1'b0, beam_line} < y_end[n];
            x_match[n] = y_act[n] && spr_x[n] == beam_x;
            // the match loads a fresh pattern and restarts both phase toggles
            src[n] = x_match[n] ? spr_data[n] : shift_reg[n];
            xe_ph[n] = xe_ff[n] & ~x_match[n];
            mc_ph[n] = mmc_ff[n] & ~x_match[n];
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            active <= '0;
            xe_ff <= '0;
            mmc_ff <= '0;
            cur_pix <= '0;
        end else if (dot_tick) begin
            for (int n = 0; n < `NUM_SPRITES; n++) begin
                if (x_match[n] || active[n]) begin
                    if (src[n] != '0 || cur_pix[n] != PIX_TRANSP) begin
                        active[n] <= 1'b1;
                        // x expansion skips every other step
                        if (!xe_ph[n]) begin
                            // multicolor holds each pair for two steps
                            if (!mc_ph[n])
                                cur_pix[n] <= spr_mmc[n] ? src[n].mc[11] :
                                              (src[n].hires[23] ? PIX_SPR : PIX_TRANSP);
                            mmc_ff[n] <= ~mc_ph[n] & spr_mmc[n];
                        end
                        xe_ff[n] <= ~xe_ph[n] & spr_xe[n];
                    end else begin
                        // pattern and current pixel both empty
                        active[n] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (dot_tick) begin
            for (int n = 0; n < `NUM_SPRITES; n++) begin
                if ((x_match[n] || active[n]) && !xe_ph[n])
                    shift_reg[n].hires <= {src[n].hires[22:0], 1'b0};
            end
        end
    end

    // line up with the graphics data, x stays with its pixel
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dot_tick_d <= 1'b0;
            for (int d = 0; d < `PIX_DELAY; d++)
                pix_dly[d] <= '0;
            for (int d = 0; d <= `PIX_DELAY; d++)
                x_dly[d] <= '0;
        end else begin
            dot_tick_d <= dot_tick;
            if (dot_tick) begin
                pix_dly[0] <= cur_pix;
                for (int d = 1; d < `PIX_DELAY; d++)
                    pix_dly[d] <= pix_dly[d-1];
                x_dly[0] <= beam_x;
                for (int d = 1; d <= `PIX_DELAY; d++)
                    x_dly[d] <= x_dly[d-1];
            end
        end
    end

    assign spr_pix = pix_dly[`PIX_DELAY-1];
    assign pix_x = x_dly[`PIX_DELAY];

endmodule

// ==== hdl/sprite_mixer.sv ====
`timescale 1ns/100ps

`include "sprite_params.svh"

module sprite_mixer (
    input  logic                                    clk_dot4x,
    input  logic                                    rst,
    input  logic                                    dot_tick_d,
    input  sprite_pkg::pix_code_t [`NUM_SPRITES-1:0] spr_pix,
    input  logic [`X_W-1:0]                         pix_x,
    input  logic                                    fg_pixel,
    input  logic                                    border,
    input  logic                                    m2m_read,
    input  logic                                    m2d_read,
    output logic                                    pix_valid,
    output sprite_pkg::pix_code_t                   pix_code,
    output logic [$clog2(`NUM_SPRITES)-1:0]         pix_sprite,
    output logic [`X_W-1:0]                         pix_x_out,
    output logic [`NUM_SPRITES-1:0]                 m2m_set,
    output logic [`NUM_SPRITES-1:0]                 m2d_set,
    output logic                                    immc,
    output logic                                    imbc
);

    import sprite_pkg::*;

    localparam int IDX_W = $clog2(`NUM_SPRITES);

    pix_code_t               win_code;
    logic [IDX_W-1:0]        win_idx;
    logic [`NUM_SPRITES-1:0] coll;
    logic [`NUM_SPRITES-1:0] data_hit;
    logic                    multi;
    // set once an interrupt has fired, cleared by reading the register
    logic                    m2m_hold;
    logic                    m2d_hold;

    always_comb begin
        win_code = PIX_TRANSP;
        win_idx = '0;
        // walk down so the lowest nonzero sprite wins
        for (int n = `NUM_SPRITES - 1; n >= 0; n--) begin
            coll[n] = spr_pix[n][1];
            if (spr_pix[n] != PIX_TRANSP) begin
                win_code = spr_pix[n];
                win_idx = IDX_W'(n);
            end
        end
        // more than one bit set
        multi = (coll & (coll - 1'b1)) != '0;
        data_hit = (fg_pixel && !border) ? coll : '0;
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pix_valid <= 1'b0;
            m2m_set <= '0;
            m2d_set <= '0;
            immc <= 1'b0;
            imbc <= 1'b0;
            m2m_hold <= 1'b0;
            m2d_hold <= 1'b0;
        end else begin
            pix_valid <= dot_tick_d;
            m2m_set <= '0;
            m2d_set <= '0;
            immc <= 1'b0;
            imbc <= 1'b0;
            if (m2m_read)
                m2m_hold <= 1'b0;
            if (m2d_read)
                m2d_hold <= 1'b0;
            if (dot_tick_d) begin
                if (multi) begin
                    m2m_set <= coll;
                    if (!m2m_hold || m2m_read) begin
                        immc <= 1'b1;
                        m2m_hold <= 1'b1;
                    end
                end
                if (data_hit != '0) begin
                    m2d_set <= data_hit;
                    if (!m2d_hold || m2d_read) begin
                        imbc <= 1'b1;
                        m2d_hold <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (dot_tick_d) begin
            pix_code <= win_code;
            pix_sprite <= win_idx;
            pix_x_out <= pix_x;
        end
    end

endmodule

// ==== hdl/sprite_video_top.sv ====
`timescale 1ns/100ps

`include "sprite_params.svh"

module sprite_video_top (
    input  logic                            clk_dot4x,
    input  logic                            rst,
    input  logic [`APB_AW-1:0]              paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`APB_DW-1:0]              pwdata,
    output logic [`APB_DW-1:0]              prdata,
    output logic                            pready,
    input  logic                            fg_pixel,
    input  logic                            border,
    output logic                            irq,
    output logic                            pix_valid,
    output sprite_pkg::pix_code_t           pix_code,
    output logic [$clog2(`NUM_SPRITES)-1:0] pix_sprite,
    output logic [`X_W-1:0]                 pix_x
);

    import sprite_pkg::*;

    logic [`NUM_SPRITES-1:0][`X_W-1:0] spr_x;
    logic [`NUM_SPRITES-1:0][`Y_W-1:0] spr_y;
    logic [`NUM_SPRITES-1:0]           spr_en;
    logic [`NUM_SPRITES-1:0]           spr_xe;
    logic [`NUM_SPRITES-1:0]           spr_ye;
    logic [`NUM_SPRITES-1:0]           spr_mmc;
    sprite_data_u [`NUM_SPRITES-1:0]   spr_data;
    logic [`NUM_SPRITES-1:0]           m2m_set;
    logic [`NUM_SPRITES-1:0]           m2d_set;
    logic                              m2m_read;
    logic                              m2d_read;
    logic                              immc;
    logic                              imbc;
    logic                              dot_tick;
    logic [`X_W-1:0]                   beam_x;
    logic [`Y_W-1:0]                   beam_line;
    logic                              dot_tick_d;
    pix_code_t [`NUM_SPRITES-1:0]      spr_pix;
    logic [`X_W-1:0]                   dly_pix_x;

    sprite_regs u_regs (
        .clk_dot4x, .rst,
        .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
        .m2m_set, .m2d_set, .immc, .imbc,
        .spr_x, .spr_y, .spr_en, .spr_xe, .spr_ye, .spr_mmc, .spr_data,
        .m2m_read, .m2d_read, .irq
    );

    beam_timer u_beam (
        .clk_dot4x, .rst,
        .dot_tick, .beam_x, .beam_line
    );

    sprite_shifter u_shifter (
        .clk_dot4x, .rst,
        .dot_tick, .beam_x, .beam_line,
        .spr_x, .spr_y, .spr_en, .spr_xe, .spr_ye, .spr_mmc, .spr_data,
        .dot_tick_d, .spr_pix,
        .pix_x (dly_pix_x)
    );

    sprite_mixer u_mixer (
        .clk_dot4x, .rst,
        .dot_tick_d, .spr_pix,
        .pix_x (dly_pix_x),
        .fg_pixel, .border, .m2m_read, .m2d_read,
        .pix_valid, .pix_code, .pix_sprite,
        .pix_x_out (pix_x),
        .m2m_set, .m2d_set, .immc, .imbc
    );

endmodule

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
    output logic clk_dot4x,
    output logic rst
);

    // 40 ns period, reset held for 16 cycles
    initial begin
        clk_dot4x = 1'b0;
        forever #20 clk_dot4x = ~clk_dot4x;
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk_dot4x);
        #1 rst = 1'b0;
    end

endmodule

// ==== tb/tb_sprite_video.sv ====
`timescale 1ns/100ps

`include "sprite_params.svh"

module tb_sprite_video;

    import sprite_pkg::*;

    localparam int FRAME_CLKS = `LINE_DOTS * `FRAME_LINES * 4;
    // seven checked frames, each waits for up to two frames
    localparam int CHECKED_FRAMES = 7;
    localparam int TEST_FRAMES = 2 * CHECKED_FRAMES;

    logic                 clk_dot4x;
    logic                 rst;
    logic [`APB_AW-1:0]   paddr;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [`APB_DW-1:0]   pwdata;
    logic [`APB_DW-1:0]   prdata;
    logic                 pready;
    logic                 fg_pixel;
    logic                 border;
    logic                 irq;
    logic                 pix_valid;
    pix_code_t            pix_code;
    logic [1:0]           pix_sprite;
    logic [`X_W-1:0]      pix_x;

    // shadow of the sprite registers
    logic [`X_W-1:0]      sx [`NUM_SPRITES];
    logic [`Y_W-1:0]      sy [`NUM_SPRITES];
    logic [23:0]          sdata [`NUM_SPRITES];
    logic [3:0]           sen;
    logic [3:0]           sxe;
    logic [3:0]           sye;
    logic [3:0]           smc;

    logic [15:0]          lfsr = 16'd41119;
    string                test_name;
    int                   frame_cnt;
    int                   chk_frame;
    int                   mon_line;
    int                   prev_x;
    int                   exp_x;
    logic                 fg_used;
    logic                 border_used;
    logic                 force_border;
    logic [3:0]           exp_m2m;
    logic [3:0]           exp_m2d;
    logic [1:0]           mon_code;
    logic [1:0]           exp_code;
    logic [1:0]           exp_idx;
    logic [3:0]           mon_coll;

    tb_clkgen clkgen (
        .clk_dot4x (clk_dot4x),
        .rst       (rst)
    );

    sprite_video_top uut (
        .clk_dot4x, .rst,
        .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
        .fg_pixel, .border,
        .irq, .pix_valid, .pix_code, .pix_sprite, .pix_x
    );

    // galois lfsr, one step per bit
    function automatic logic [31:0] rnd(input int w);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < w; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // expected code of sprite n at a beam position
    function automatic logic [1:0] model_code(input int n, input int line, input int x);
        int h;
        int k;
        int s;
        if (!sen[n])
            return 2'd0;
        h = sye[n] ? 2 * `SPRITE_LINES : `SPRITE_LINES;
        if (line < int'(sy[n]) || line >= int'(sy[n]) + h || x < int'(sx[n]))
            return 2'd0;
        k = x - int'(sx[n]);
        s = sxe[n] ? k / 2 : k;
        if (s >= 24)
            return 2'd0;
        // multicolor steps through the pairs, two steps each
        if (smc[n])
            return 2'(sdata[n] >> (22 - 2 * (s / 2)));
        return sdata[n][23-s] ? 2'd2 : 2'd0;
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic apb_write(input logic [7:0] a, input logic [31:0] d);
        @(posedge clk_dot4x) #1;
        paddr = a;
        pwdata = d;
        pwrite = 1'b1;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clk_dot4x) #1 penable = 1'b1;
        @(negedge clk_dot4x);
        while (!pready)
            @(negedge clk_dot4x);
        @(posedge clk_dot4x) #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] a, output logic [31:0] d);
        @(posedge clk_dot4x) #1;
        paddr = a;
        pwrite = 1'b0;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clk_dot4x) #1 penable = 1'b1;
        @(negedge clk_dot4x);
        while (!pready)
            @(negedge clk_dot4x);
        d = prdata;
        @(posedge clk_dot4x) #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_sprite(input int n, input logic [6:0] x, input logic [5:0] y,
                              input logic [23:0] d);
        sx[n] = x;
        sy[n] = y;
        sdata[n] = d;
        apb_write(`A_SPR_X + 8'(4 * n), 32'(x));
        apb_write(`A_SPR_Y + 8'(4 * n), 32'(y));
        apb_write(`A_SPR_DATA + 8'(4 * n), 32'(d));
    endtask

    task automatic set_ctrl(input logic [3:0] en, input logic [3:0] xe, input logic [3:0] ye,
                            input logic [3:0] mc);
        sen = en;
        sxe = xe;
        sye = ye;
        smc = mc;
        apb_write(`A_EN, 32'(en));
        apb_write(`A_XE, 32'(xe));
        apb_write(`A_YE, 32'(ye));
        apb_write(`A_MMC, 32'(mc));
        // let pixels from the old setup drain out of the pipeline
        repeat (24) @(posedge clk_dot4x);
    endtask

    // flags first, so the reads re-arm the interrupts for the next hit
    task automatic clear_coll();
        logic [31:0] d;
        apb_write(`A_IRQ, 32'h3);
        apb_read(`A_M2M, d);
        apb_read(`A_M2D, d);
    endtask

    // compare one whole frame against the model
    task automatic check_frame();
        int f;
        f = frame_cnt;
        exp_m2m = '0;
        exp_m2d = '0;
        chk_frame = f + 1;
        wait (frame_cnt == f + 2);
    endtask

    // pixel monitor, tracks the line from the x wrap
    always @(negedge clk_dot4x) begin
        if (!rst && pix_valid) begin
            exp_x = (prev_x + 1) % `LINE_DOTS;
            if (pix_x == 0 && prev_x == `LINE_DOTS - 1) begin
                mon_line = (mon_line == `FRAME_LINES - 1) ? 0 : mon_line + 1;
                if (mon_line == 0)
                    frame_cnt++;
            end
            prev_x = int'(pix_x);
            if (frame_cnt == chk_frame) begin
                // one pixel per dot, in beam order
                check_val("pix_x", 32'(exp_x), 32'(pix_x));
                exp_code = 2'd0;
                exp_idx = 2'd0;
                for (int n = `NUM_SPRITES - 1; n >= 0; n--) begin
                    mon_code = model_code(n, mon_line, int'(pix_x));
                    mon_coll[n] = mon_code[1];
                    if (mon_code != 2'd0) begin
                        exp_code = mon_code;
                        exp_idx = 2'(n);
                    end
                end
                check_val("pix_code", 32'(exp_code), 32'(pix_code));
                check_val("pix_sprite", 32'(exp_idx), 32'(pix_sprite));
                if ($countones(mon_coll) > 1)
                    exp_m2m = exp_m2m | mon_coll;
                if (fg_used && !border_used)
                    exp_m2d = exp_m2d | mon_coll;
            end
        end
    end

    // graphics inputs change once per dot, right after the mixer took them
    always @(posedge clk_dot4x) begin
        #1;
        if (pix_valid) begin
            fg_used = fg_pixel;
            border_used = border;
            if (frame_cnt == chk_frame && mon_line < `FRAME_LINES - 1) begin
                fg_pixel = 1'(rnd(1));
                border = force_border ? 1'b1 : 1'(rnd(1));
            end else begin
                fg_pixel = 1'b0;
                border = force_border;
            end
        end
    end

    initial begin
        repeat (TEST_FRAMES * FRAME_CLKS + 20000) @(posedge clk_dot4x);
        $display("watchdog expired before the tests completed");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    initial begin
        logic [31:0] d;
        logic [3:0]  c [4];
        int          n;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        fg_pixel = 1'b0;
        border = 1'b0;
        force_border = 1'b0;
        fg_used = 1'b0;
        border_used = 1'b0;
        frame_cnt = 0;
        chk_frame = -1;
        mon_line = 0;
        prev_x = 0;
        exp_x = 0;
        sen = '0;
        sxe = '0;
        sye = '0;
        smc = '0;
        #1;
        wait (rst == 1'b0);

        test_name = "regs";
        apb_read(`A_M2M, d);
        check_val("m2m after reset", 0, d);
        apb_read(`A_M2D, d);
        check_val("m2d after reset", 0, d);
        apb_read(`A_IRQ, d);
        check_val("irq reg after reset", 0, d);
        for (int i = 0; i < `NUM_SPRITES; i++)
            set_sprite(i, 7'(rnd(7)), 6'(rnd(6)), 24'(rnd(24)));
        for (int i = 0; i < 4; i++)
            c[i] = 4'(rnd(4));
        set_ctrl(c[0], c[1], c[2], c[3]);
        for (int i = 0; i < `NUM_SPRITES; i++) begin
            apb_read(`A_SPR_X + 8'(4 * i), d);
            check_val("spr_x", 32'(sx[i]), d);
            apb_read(`A_SPR_Y + 8'(4 * i), d);
            check_val("spr_y", 32'(sy[i]), d);
            apb_read(`A_SPR_DATA + 8'(4 * i), d);
            check_val("spr_data", 32'(sdata[i]), d);
        end
        apb_read(`A_EN, d);
        check_val("en", 32'(sen), d);
        apb_read(`A_XE, d);
        check_val("xe", 32'(sxe), d);
        apb_read(`A_YE, d);
        check_val("ye", 32'(sye), d);
        apb_read(`A_MMC, d);
        check_val("mmc", 32'(smc), d);
        set_ctrl(4'h0, 4'h0, 4'h0, 4'h0);

        // single sprite, hi-res then multicolor, each without and with x expansion
        for (int mc = 0; mc < 2; mc++) begin
            if (mc != 0)
                test_name = "multicolor";
            else
                test_name = "hires";
            for (int xe = 0; xe < 2; xe++) begin
                n = int'(rnd(2));
                set_sprite(n, 7'(rnd(6) % 48), 6'(rnd(6) % 48), 24'(rnd(24)));
                set_ctrl(4'(1 << n), 4'(xe << n), 4'(rnd(1) << n), 4'(mc << n));
                check_frame();
            end
        end

        // sprites 0 and 1 share a corner so they always overlap
        test_name = "priority_m2m";
        for (int i = 0; i < `NUM_SPRITES; i++)
            set_sprite(i, 7'(rnd(6) % 48), 6'(rnd(6) % 48), 24'(rnd(24)) | 24'h800000);
        set_sprite(1, sx[0], sy[0], sdata[1]);
        set_ctrl(4'hf, 4'(rnd(4)), 4'(rnd(4)), 4'h0);
        clear_coll();
        check_frame();
        check_val("irq", 1, 32'(irq));
        set_ctrl(4'h0, 4'h0, 4'h0, 4'h0);
        repeat (2 * `LINE_DOTS * 4) @(posedge clk_dot4x);
        apb_read(`A_M2M, d);
        check_val("m2m", 32'(exp_m2m), d);
        apb_read(`A_M2M, d);
        check_val("m2m after read", 0, d);
        apb_write(`A_IRQ, 32'h3);
        check_val("irq after clear", 0, 32'(irq));

        test_name = "m2d";
        for (int i = 0; i < `NUM_SPRITES; i++)
            set_sprite(i, 7'(rnd(6) % 48), 6'(rnd(6) % 48), 24'(rnd(24)));
        set_ctrl(4'hf, 4'(rnd(4)), 4'(rnd(4)), 4'(rnd(4)));
        clear_coll();
        check_frame();
        apb_read(`A_M2D, d);
        check_val("m2d", 32'(exp_m2d), d);

        // border covers everything, so no data hits
        test_name = "m2d_border";
        force_border = 1'b1;
        repeat (8) @(posedge clk_dot4x);
        clear_coll();
        check_frame();
        apb_read(`A_M2D, d);
        check_val("m2d", 0, d);
        force_border = 1'b0;

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/sprite_pkg.sv
hdl/sprite_regs.sv
hdl/beam_timer.sv
hdl/sprite_shifter.sv
hdl/sprite_mixer.sv
hdl/sprite_video_top.sv
tb/tb_clkgen.sv
tb/tb_sprite_video.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing -Wno-fatal
TOP       ?= tb_sprite_video
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJDIR) -o sim_$(TOP)
	./$(OBJDIR)/sim_$(TOP)

clean:
	rm -rf $(OBJDIR)
